/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module pipeline_mux_tb

# The run counts as passed only when the testbench prints its pass line
out=$(./obj_dir/Vpipeline_mux_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q -F '*** PASSED ***'

/* sim.f */
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/group_if.sv
source/fetch_align.sv
source/group_stage.sv
source/flow_detect.sv
source/pipeline_mux.sv
tests/pipeline_mux_props.sv
tests/pipeline_mux_tb.sv

/* source/fetch_align.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_macros.svh"

module fetch_align (
	input  wire                                    clk,
	input  wire                                    rst_i,
	input  wire                                    advance_i,
	input  wire pipe_pkg::pc_t                     pc_i,
	input  wire [`LINE_WORDS*`INSN_BITS-1:0]       line_i,
	output pipe_pkg::group_t                       slots_o,
	output logic                                   redundant_o
);

	logic [2*`LINE_WORDS*`INSN_BITS-1:0] padded;
	logic [`LINE_WORDS*`INSN_BITS-1:0]   aligned;
	logic [`LINE_WORDS*`INSN_BITS-1:0]   prev_aligned;
	pipe_pkg::pc_t                       prev_pc;

	// ==================================================
	// Line alignment
	// ==================================================

	// Words shifted in from above the line end up as NOPs
	always_comb begin
		padded = {{`LINE_WORDS{isa_pkg::NOP_INSN}}, line_i} >> (pc_i[4:2] * `INSN_BITS);
		aligned = padded[`LINE_WORDS*`INSN_BITS-1:0];
	end

	always_comb begin
		for (int k = 0; k < `GROUP_SLOTS; k++) begin
			slots_o[k] = pipe_pkg::nop_slot(pc_i + pipe_pkg::pc_t'(4 * k));
			slots_o[k].insn = isa_pkg::insn_t'(aligned[k*`INSN_BITS +: `INSN_BITS]);
			slots_o[k].v = 1'b1;
		end
	end

	// ==================================================
	// Redundant group detection
	// ==================================================

	// History of the last group that fetch moved past
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_pc <= '0;
			prev_aligned <= '0;
		end else if (advance_i) begin
			prev_pc <= pc_i;
			prev_aligned <= aligned;
		end
	end

	// Same address and same words means fetch is replaying the old group
	assign redundant_o = (prev_pc == pc_i) && (prev_aligned == aligned);

endmodule

`default_nettype wire

/* source/flow_detect.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_macros.svh"

module flow_detect (
	group_if.flow          grp,
	output logic           do_bsr_o,
	output logic           do_call_o,
	output logic           do_ret_o,
	output pipe_pkg::pc_t  bsr_tgt_o,
	output pipe_pkg::pc_t  ret_pc_o
);

	isa_pkg::flow_e kind [`GROUP_SLOTS];
	pipe_pkg::pc_t  tgt  [`GROUP_SLOTS];
	pipe_pkg::pc_t  ret  [`GROUP_SLOTS];
	logic           found;

	// Word displacement turned into a byte offset
	function automatic pipe_pkg::pc_t disp_offset(input isa_pkg::insn_t insn);
		pipe_pkg::pc_t ext;
		ext = pipe_pkg::pc_t'($signed(insn.bsr.disp));
		return ext << 2;
	endfunction

	// Rt of zero turns a call into a plain jump
	function automatic isa_pkg::flow_e classify(input pipe_pkg::slot_t s);
		isa_pkg::flow_e f;
		f = isa_pkg::FLOW_NONE;
		if (s.v) begin
			case (s.insn.bsr.opcode)
				isa_pkg::OP_BSR,
				isa_pkg::OP_JSR:
					f = (s.insn.bsr.rt != 3'd0) ? isa_pkg::FLOW_CALL_DIRECT
						: isa_pkg::FLOW_BRANCH;
				isa_pkg::OP_JSRR,
				isa_pkg::OP_JSRI:
					if (s.insn.bsr.rt != 3'd0)
						f = isa_pkg::FLOW_CALL_INDIRECT;
				isa_pkg::OP_RTD:
					if (s.insn.rtd.typ == 2'd0)
						f = isa_pkg::FLOW_RETURN;
				default:
					f = isa_pkg::FLOW_NONE;
			endcase
		end
		return f;
	endfunction

	// ==================================================
	// Per slot classification
	// ==================================================

	always_comb begin
		for (int k = 0; k < `GROUP_SLOTS; k++) begin
			kind[k] = classify(grp.slots[k]);
			// BSR is PC relative, JSR jumps to an absolute address
			if (grp.slots[k].insn.bsr.opcode == isa_pkg::OP_BSR)
				tgt[k] = grp.slots[k].pc + disp_offset(grp.slots[k].insn);
			else
				tgt[k] = disp_offset(grp.slots[k].insn);
			ret[k] = grp.slots[k].pc + pipe_pkg::pc_t'(4);
		end
	end

	// ==================================================
	// First flow change in program order
	// ==================================================

	always_comb begin
		do_bsr_o = 1'b0;
		do_call_o = 1'b0;
		do_ret_o = 1'b0;
		bsr_tgt_o = `RSTPC;
		ret_pc_o = `RSTPC;
		found = 1'b0;
		for (int k = 0; k < `GROUP_SLOTS; k++) begin
			if (!found && !grp.nop && kind[k] != isa_pkg::FLOW_NONE) begin
				found = 1'b1;
				do_bsr_o = (kind[k] == isa_pkg::FLOW_BRANCH) ||
					(kind[k] == isa_pkg::FLOW_CALL_DIRECT);
				do_call_o = (kind[k] == isa_pkg::FLOW_CALL_DIRECT) ||
					(kind[k] == isa_pkg::FLOW_CALL_INDIRECT);
				do_ret_o = (kind[k] == isa_pkg::FLOW_RETURN);
				if (do_bsr_o)
					bsr_tgt_o = tgt[k];
				if (do_call_o)
					ret_pc_o = ret[k];
			end
		end
	end

endmodule

`default_nettype wire

/* source/group_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Registered instruction group on its way to the flow decoder
// Contents are valid every cycle once reset is released
interface group_if;

	pipe_pkg::group_t slots;

	// Group was loaded while a stomp was active
	logic nop;

	modport stage (
		output slots,
		output nop
	);

	modport flow (
		input slots,
		input nop
	);

endinterface

`default_nettype wire

/* source/group_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_macros.svh"

module group_stage (
	input  wire                    clk,
	input  wire                    rst_i,
	input  wire                    en_i,
	input  wire pipe_pkg::group_t  slots_i,
	input  wire                    redundant_i,
	input  wire                    nmi_i,
	input  wire                    irq_i,
	input  wire [2:0]              irq_level_i,
	input  wire                    stomp_i,
	input  wire                    branchmiss_i,
	input  wire pipe_pkg::pc_t     misspc_i,
	group_if.stage                 grp
);

	pipe_pkg::group_t next_grp;
	logic             intr;
	logic [`GROUP_SLOTS-1:0] squash;

	// An external interrupt takes the whole group
	assign intr = nmi_i || irq_i;

	// ==================================================
	// Slot rules
	// ==================================================

	always_comb begin
		for (int k = 0; k < `GROUP_SLOTS; k++) begin
			// Slots ahead of the miss address were already executed on the
			// wrong path and must not run again
			squash[k] = redundant_i || (branchmiss_i && (slots_i[k].pc < misspc_i));

			next_grp[k] = slots_i[k];
			if (squash[k])
				next_grp[k].insn = isa_pkg::NOP_INSN;

			// Interrupted slots are replayed later, so they carry the level
			// but are not valid now
			next_grp[k].hwi = intr;
			next_grp[k].hwi_level = irq_level_i;
			next_grp[k].v = !intr && !stomp_i;
		end
	end

	// ==================================================
	// Group register
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int k = 0; k < `GROUP_SLOTS; k++)
				grp.slots[k] <= pipe_pkg::nop_slot(`RSTPC);
			grp.nop <= 1'b0;
		end else if (en_i) begin
			grp.slots <= next_grp;
			grp.nop <= stomp_i;
		end
	end

endmodule

`default_nettype wire

/* source/isa_pkg.sv */
`default_nettype none

`include "pipe_macros.svh"

package isa_pkg;

	// ==================================================
	// Opcodes seen by the front end
	// ==================================================

	typedef enum logic [6:0] {
		OP_NOP  = 7'h0F,
		OP_ADD  = 7'h04,
		OP_BSR  = 7'h20,
		OP_JSR  = 7'h21,
		OP_JSRR = 7'h22,
		OP_JSRI = 7'h23,
		OP_RTD  = 7'h24
	} opcode_e;

	typedef logic [2:0] regno_t;
	typedef logic [`INSN_BITS-11:0] disp_t;

	// Branch and call format, also used to read Rt of any instruction
	typedef struct packed {
		disp_t   disp;
		regno_t  rt;
		opcode_e opcode;
	} bsr_fmt_t;

	// Return format, the type sits in the low bits of the displacement
	typedef struct packed {
		logic [`INSN_BITS-13:0] amt;
		logic [1:0]             typ;
		regno_t                 rt;
		opcode_e                opcode;
	} rtd_fmt_t;

	typedef union packed {
		bsr_fmt_t bsr;
		rtd_fmt_t rtd;
	} insn_t;

	// How a slot changes the flow of control
	typedef enum logic [2:0] {
		FLOW_NONE,
		FLOW_BRANCH,
		FLOW_CALL_DIRECT,
		FLOW_CALL_INDIRECT,
		FLOW_RETURN
	} flow_e;

	localparam insn_t NOP_INSN = insn_t'({{(`INSN_BITS-7){1'b0}}, OP_NOP});

endpackage

`default_nettype wire

/* source/pipe_macros.svh */
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// ==================================================
// Front end geometry
// ==================================================

// Instruction slots handed to decode each cycle
`define GROUP_SLOTS 4

// Instruction words held in one cache line
`define LINE_WORDS 8

`define INSN_BITS 32
`define PC_BITS 32

// Fetch address after reset, also the default flow target
`define RSTPC 32'hFFFD0000

`endif

/* source/pipe_pkg.sv */
`default_nettype none

`include "pipe_macros.svh"

package pipe_pkg;

	typedef logic [`PC_BITS-1:0] pc_t;

	// One instruction slot as it travels toward decode
	typedef struct packed {
		isa_pkg::insn_t insn;
		pc_t            pc;
		logic           v;
		logic           hwi;
		logic [2:0]     hwi_level;
	} slot_t;

	typedef slot_t [`GROUP_SLOTS-1:0] group_t;

	// An empty slot at the given address
	// Not valid and not interrupted
	function automatic slot_t nop_slot(input pc_t pc);
		slot_t s;
		s.insn = isa_pkg::NOP_INSN;
		s.pc = pc;
		s.v = 1'b0;
		s.hwi = 1'b0;
		s.hwi_level = 3'd0;
		return s;
	endfunction

endpackage

`default_nettype wire

/* source/pipeline_mux.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_macros.svh"

// Fetch to decode instruction mux
// Align, filter and register one group, then resolve its first flow change
module pipeline_mux (
	input  wire                                   clk,
	input  wire                                   rst_i,
	input  wire                                   en_i,
	input  wire                                   advance_i,
	input  wire pipe_pkg::pc_t                    pc_i,
	input  wire [`LINE_WORDS*`INSN_BITS-1:0]      line_i,
	input  wire                                   nmi_i,
	input  wire                                   irq_i,
	input  wire [2:0]                             irq_level_i,
	input  wire                                   stomp_i,
	input  wire                                   branchmiss_i,
	input  wire pipe_pkg::pc_t                    misspc_i,
	output isa_pkg::insn_t [`GROUP_SLOTS-1:0]     slot_ins_o,
	output pipe_pkg::pc_t [`GROUP_SLOTS-1:0]      slot_pc_o,
	output logic [`GROUP_SLOTS-1:0]               slot_v_o,
	output logic [`GROUP_SLOTS-1:0]               slot_hwi_o,
	output logic [2:0]                            slot_hwi_level_o,
	output logic                                  nop_o,
	output logic                                  do_bsr_o,
	output logic                                  do_call_o,
	output logic                                  do_ret_o,
	output pipe_pkg::pc_t                         bsr_tgt_o,
	output pipe_pkg::pc_t                         ret_pc_o
);

	pipe_pkg::group_t raw_slots;
	logic             redundant;

	group_if u_grp_if ();

	fetch_align u_align (
		.clk         (clk),
		.rst_i       (rst_i),
		.advance_i   (advance_i),
		.pc_i        (pc_i),
		.line_i      (line_i),
		.slots_o     (raw_slots),
		.redundant_o (redundant)
	);

	group_stage u_stage (
		.clk          (clk),
		.rst_i        (rst_i),
		.en_i         (en_i),
		.slots_i      (raw_slots),
		.redundant_i  (redundant),
		.nmi_i        (nmi_i),
		.irq_i        (irq_i),
		.irq_level_i  (irq_level_i),
		.stomp_i      (stomp_i),
		.branchmiss_i (branchmiss_i),
		.misspc_i     (misspc_i),
		.grp          (u_grp_if.stage)
	);

	flow_detect u_flow (
		.grp       (u_grp_if.flow),
		.do_bsr_o  (do_bsr_o),
		.do_call_o (do_call_o),
		.do_ret_o  (do_ret_o),
		.bsr_tgt_o (bsr_tgt_o),
		.ret_pc_o  (ret_pc_o)
	);

	for (genvar k = 0; k < `GROUP_SLOTS; k++) begin : g_fan
		assign slot_ins_o[k] = u_grp_if.slots[k].insn;
		assign slot_pc_o[k] = u_grp_if.slots[k].pc;
		assign slot_v_o[k] = u_grp_if.slots[k].v;
		assign slot_hwi_o[k] = u_grp_if.slots[k].hwi;
	end

	// Every slot of a group is loaded with the same level
	assign slot_hwi_level_o = u_grp_if.slots[0].hwi_level;
	assign nop_o = u_grp_if.nop;

endmodule

`default_nettype wire

/* tests/pipeline_mux_props.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_macros.svh"

module pipeline_mux_props (
	input wire                                 clk,
	input wire                                 rst_i,
	input wire                                 en_i,
	input wire [`GROUP_SLOTS*`INSN_BITS-1:0]   slot_ins_i,
	input wire [`GROUP_SLOTS*`PC_BITS-1:0]     slot_pc_i,
	input wire [`GROUP_SLOTS-1:0]              slot_v_i,
	input wire [`GROUP_SLOTS-1:0]              slot_hwi_i,
	input wire [2:0]                           slot_hwi_level_i,
	input wire                                 nop_i,
	input wire                                 do_bsr_i,
	input wire                                 do_ret_i
);

	// Only one slot wins, and it is either a branch or a return
	a_bsr_ret: assert property (@(posedge clk) disable iff (rst_i)
		!(do_bsr_i && do_ret_i))
		else $error("do_bsr and do_ret are high together");

	// Interrupted slots are replayed later and never valid now
	a_valid_hwi: assert property (@(posedge clk) disable iff (rst_i)
		(slot_v_i & slot_hwi_i) == '0)
		else $error("valid slot has hwi set");

	// Back-pressure keeps the registered group frozen
	a_hold: assert property (@(posedge clk) disable iff (rst_i)
		!en_i |=> $stable(slot_ins_i) && $stable(slot_pc_i) && $stable(slot_v_i)
			&& $stable(slot_hwi_i) && $stable(slot_hwi_level_i) && $stable(nop_i))
		else $error("outputs changed while en_i was low");

endmodule

bind pipeline_mux pipeline_mux_props u_props (
	.clk              (clk),
	.rst_i            (rst_i),
	.en_i             (en_i),
	.slot_ins_i       (slot_ins_o),
	.slot_pc_i        (slot_pc_o),
	.slot_v_i         (slot_v_o),
	.slot_hwi_i       (slot_hwi_o),
	.slot_hwi_level_i (slot_hwi_level_o),
	.nop_i            (nop_o),
	.do_bsr_i         (do_bsr_o),
	.do_ret_i         (do_ret_o)
);

`default_nettype wire

/* tests/pipeline_mux_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_macros.svh"

module pipeline_mux_tb;

	localparam int ALIGN_RUNS = 16;
	localparam int FLOW_RUNS = 40;
	// Two cycles per group load, plus reset and the short directed tests
	localparam int TEST_CYCLES = 2 * (ALIGN_RUNS + FLOW_RUNS) + 40;
	localparam isa_pkg::insn_t NOP_WORD =
		isa_pkg::insn_t'({{(`INSN_BITS-7){1'b0}}, isa_pkg::OP_NOP});

	logic                                clk;
	logic                                rst_i;
	logic                                en_i;
	logic                                advance_i;
	pipe_pkg::pc_t                       pc_i;
	logic [`LINE_WORDS*`INSN_BITS-1:0]   line_i;
	logic                                nmi_i;
	logic                                irq_i;
	logic [2:0]                          irq_level_i;
	logic                                stomp_i;
	logic                                branchmiss_i;
	pipe_pkg::pc_t                       misspc_i;
	isa_pkg::insn_t [`GROUP_SLOTS-1:0]   slot_ins_o;
	pipe_pkg::pc_t [`GROUP_SLOTS-1:0]    slot_pc_o;
	logic [`GROUP_SLOTS-1:0]             slot_v_o;
	logic [`GROUP_SLOTS-1:0]             slot_hwi_o;
	logic [2:0]                          slot_hwi_level_o;
	logic                                nop_o;
	logic                                do_bsr_o;
	logic                                do_call_o;
	logic                                do_ret_o;
	pipe_pkg::pc_t                       bsr_tgt_o;
	pipe_pkg::pc_t                       ret_pc_o;

	logic [31:0] lfsr;
	int          checks;
	int          errors;

	pipeline_mux u_dut (
		.clk (clk), .rst_i (rst_i), .en_i (en_i), .advance_i (advance_i),
		.pc_i (pc_i), .line_i (line_i), .nmi_i (nmi_i), .irq_i (irq_i),
		.irq_level_i (irq_level_i), .stomp_i (stomp_i),
		.branchmiss_i (branchmiss_i), .misspc_i (misspc_i),
		.slot_ins_o (slot_ins_o), .slot_pc_o (slot_pc_o), .slot_v_o (slot_v_o),
		.slot_hwi_o (slot_hwi_o), .slot_hwi_level_o (slot_hwi_level_o),
		.nop_o (nop_o), .do_bsr_o (do_bsr_o), .do_call_o (do_call_o),
		.do_ret_o (do_ret_o), .bsr_tgt_o (bsr_tgt_o), .ret_pc_o (ret_pc_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#(TEST_CYCLES * 20 * 2);
		$display("Run timed out after %0d cycles without finishing the tests",
			TEST_CYCLES * 2);
		$display("*** FAILED ***");
		$finish;
	end

	// ==================================================
	// Random numbers and expected values
	// ==================================================

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	function automatic logic [`LINE_WORDS*`INSN_BITS-1:0] random_line();
		logic [`LINE_WORDS*`INSN_BITS-1:0] l;
		for (int w = 0; w < `LINE_WORDS; w++)
			l[w*`INSN_BITS +: `INSN_BITS] = rand_bits(32);
		return l;
	endfunction

	// Mostly plain ADDs so that some groups hold no flow change at all
	function automatic isa_pkg::insn_t random_insn();
		isa_pkg::opcode_e op;
		case (4'(rand_bits(4)))
			4'd0: op = isa_pkg::OP_NOP;
			4'd1: op = isa_pkg::OP_BSR;
			4'd2: op = isa_pkg::OP_JSR;
			4'd3: op = isa_pkg::OP_JSRR;
			4'd4: op = isa_pkg::OP_JSRI;
			4'd5: op = isa_pkg::OP_RTD;
			default: op = isa_pkg::OP_ADD;
		endcase
		return isa_pkg::insn_t'({22'(rand_bits(22)), 3'(rand_bits(3)), op});
	endfunction

	// Word idx of the line, or a NOP once idx runs past the end
	function automatic isa_pkg::insn_t aligned_word(
		input logic [`LINE_WORDS*`INSN_BITS-1:0] line, input int idx);
		if (idx >= `LINE_WORDS)
			return NOP_WORD;
		return isa_pkg::insn_t'(line[idx*`INSN_BITS +: `INSN_BITS]);
	endfunction

	// First call, jump or return in slot order, with RSTPC as the default
	task automatic expected_flow(input pipe_pkg::pc_t pc,
		input logic [`LINE_WORDS*`INSN_BITS-1:0] line, output logic bsr,
		output logic call, output logic ret, output pipe_pkg::pc_t tgt,
		output pipe_pkg::pc_t rpc);
		logic [31:0]   w;
		pipe_pkg::pc_t spc;
		pipe_pkg::pc_t off;
		logic          found;
		bsr = 1'b0;
		call = 1'b0;
		ret = 1'b0;
		tgt = `RSTPC;
		rpc = `RSTPC;
		found = 1'b0;
		for (int k = 0; k < `GROUP_SLOTS; k++) begin
			w = line[k*`INSN_BITS +: `INSN_BITS];
			spc = pc + pipe_pkg::pc_t'(4 * k);
			off = {{8{w[31]}}, w[31:10], 2'b00};
			if (!found) begin
				if (w[6:0] == isa_pkg::OP_BSR || w[6:0] == isa_pkg::OP_JSR) begin
					found = 1'b1;
					bsr = 1'b1;
					tgt = (w[6:0] == isa_pkg::OP_BSR) ? spc + off : off;
				end
				if ((w[6:0] == isa_pkg::OP_JSRR || w[6:0] == isa_pkg::OP_JSRI)
					&& w[9:7] != 3'd0)
					found = 1'b1;
				if (found && w[9:7] != 3'd0) begin
					call = 1'b1;
					rpc = spc + 32'd4;
				end
				if (w[6:0] == isa_pkg::OP_RTD && w[11:10] == 2'd0) begin
					found = 1'b1;
					ret = 1'b1;
				end
			end
		end
	endtask

	// ==================================================
	// Compare tasks and stimulus
	// ==================================================

	task automatic check_insn(input string what, input isa_pkg::insn_t got,
		input isa_pkg::insn_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_pc(input string what, input pipe_pkg::pc_t got,
		input pipe_pkg::pc_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_level(input string what, input logic [2:0] got,
		input logic [2:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Load one group and stop at the falling edge after it is registered
	task automatic apply_group(input pipe_pkg::pc_t pc,
		input logic [`LINE_WORDS*`INSN_BITS-1:0] line, input logic adv,
		input logic [1:0] intr, input logic [2:0] level, input logic stomp,
		input logic bmiss, input pipe_pkg::pc_t mpc);
		@(posedge clk);
		en_i <= 1'b1;
		advance_i <= adv;
		pc_i <= pc;
		line_i <= line;
		nmi_i <= intr[1];
		irq_i <= intr[0];
		irq_level_i <= level;
		stomp_i <= stomp;
		branchmiss_i <= bmiss;
		misspc_i <= mpc;
		@(posedge clk);
		en_i <= 1'b0;
		advance_i <= 1'b0;
		nmi_i <= 1'b0;
		irq_i <= 1'b0;
		stomp_i <= 1'b0;
		branchmiss_i <= 1'b0;
		@(negedge clk);
	endtask

	task automatic check_words(input pipe_pkg::pc_t pc,
		input logic [`LINE_WORDS*`INSN_BITS-1:0] line, input int idx);
		for (int k = 0; k < `GROUP_SLOTS; k++) begin
			check_insn($sformatf("slot %0d insn", k), slot_ins_o[k],
				aligned_word(line, idx + k));
			check_pc($sformatf("slot %0d pc", k), slot_pc_o[k],
				pc + pipe_pkg::pc_t'(4 * k));
			check_flag($sformatf("slot %0d v", k), slot_v_o[k], 1'b1);
		end
	endtask

	task automatic report_test(input string name, input int base);
		$display("Test %-12s done, %0d errors", name, errors - base);
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic test_reset();
		int base;
		base = errors;
		@(negedge clk);
		for (int k = 0; k < `GROUP_SLOTS; k++) begin
			check_flag($sformatf("slot %0d v", k), slot_v_o[k], 1'b0);
			check_insn($sformatf("slot %0d insn", k), slot_ins_o[k], NOP_WORD);
		end
		check_flag("nop_o", nop_o, 1'b0);
		check_flag("do_bsr_o", do_bsr_o, 1'b0);
		check_flag("do_call_o", do_call_o, 1'b0);
		check_flag("do_ret_o", do_ret_o, 1'b0);
		report_test("reset", base);
	endtask

	task automatic test_alignment();
		pipe_pkg::pc_t                     pc;
		logic [`LINE_WORDS*`INSN_BITS-1:0] line;
		int                                base;
		base = errors;
		for (int n = 0; n < ALIGN_RUNS; n++) begin
			line = random_line();
			pc = {27'(rand_bits(27)), 3'(n % 8), 2'b00};
			apply_group(pc, line, 1'b0, 2'b00, 3'd0, 1'b0, 1'b0, '0);
			check_words(pc, line, n % 8);
		end
		report_test("alignment", base);
	endtask

	task automatic test_redundant();
		pipe_pkg::pc_t                     pc;
		logic [`LINE_WORDS*`INSN_BITS-1:0] line;
		int                                base;
		base = errors;
		line = random_line();
		pc = {27'(rand_bits(27)), 3'd2, 2'b00};
		apply_group(pc, line, 1'b1, 2'b00, 3'd0, 1'b0, 1'b0, '0);
		check_words(pc, line, 2);
		apply_group(pc, line, 1'b1, 2'b00, 3'd0, 1'b0, 1'b0, '0);
		for (int k = 0; k < `GROUP_SLOTS; k++)
			check_insn($sformatf("repeat slot %0d insn", k), slot_ins_o[k], NOP_WORD);
		apply_group(pc + 32'd4, line, 1'b1, 2'b00, 3'd0, 1'b0, 1'b0, '0);
		check_words(pc + 32'd4, line, 3);
		// New inputs with en_i low must not reach the group register
		@(posedge clk);
		pc_i <= pc + 32'h100;
		line_i <= random_line();
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_words(pc + 32'd4, line, 3);
		report_test("redundant", base);
	endtask

	task automatic test_interrupt();
		pipe_pkg::pc_t                     pc;
		logic [`LINE_WORDS*`INSN_BITS-1:0] line;
		logic [2:0]                        level;
		int                                base;
		base = errors;
		for (int n = 0; n < 2; n++) begin
			line = random_line();
			pc = {27'(rand_bits(27)), 5'd0};
			level = 3'(rand_bits(3));
			apply_group(pc, line, 1'b0, (n == 0) ? 2'b10 : 2'b01, level, 1'b0, 1'b0, '0);
			for (int k = 0; k < `GROUP_SLOTS; k++) begin
				check_flag($sformatf("interrupted slot %0d v", k), slot_v_o[k], 1'b0);
				check_flag($sformatf("interrupted slot %0d hwi", k), slot_hwi_o[k], 1'b1);
			end
			check_level("hwi_level", slot_hwi_level_o, level);
		end
		line = random_line();
		// A call in the first slot would resolve if the stomp were ignored
		line[`INSN_BITS-1:0] = {22'(rand_bits(22)), 3'd1, isa_pkg::OP_JSR};
		apply_group(pc, line, 1'b0, 2'b00, 3'd0, 1'b1, 1'b0, '0);
		for (int k = 0; k < `GROUP_SLOTS; k++)
			check_flag($sformatf("stomped slot %0d v", k), slot_v_o[k], 1'b0);
		check_flag("nop_o", nop_o, 1'b1);
		check_flag("do_bsr_o", do_bsr_o, 1'b0);
		check_flag("do_call_o", do_call_o, 1'b0);
		check_flag("do_ret_o", do_ret_o, 1'b0);
		report_test("interrupt", base);
	endtask

	task automatic test_branch_miss();
		pipe_pkg::pc_t                     pc;
		logic [`LINE_WORDS*`INSN_BITS-1:0] line;
		int                                base;
		base = errors;
		for (int m = 0; m < `GROUP_SLOTS; m++) begin
			line = random_line();
			pc = {27'(rand_bits(27)), 3'd1, 2'b00};
			apply_group(pc, line, 1'b0, 2'b00, 3'd0, 1'b0, 1'b1,
				pc + pipe_pkg::pc_t'(4 * m));
			for (int k = 0; k < `GROUP_SLOTS; k++)
				check_insn($sformatf("miss %0d slot %0d insn", m, k), slot_ins_o[k],
					(k < m) ? NOP_WORD : aligned_word(line, 1 + k));
		end
		report_test("branch miss", base);
	endtask

	task automatic test_flow();
		pipe_pkg::pc_t                     pc;
		logic [`LINE_WORDS*`INSN_BITS-1:0] line;
		logic                              bsr;
		logic                              call;
		logic                              ret;
		pipe_pkg::pc_t                     tgt;
		pipe_pkg::pc_t                     rpc;
		int                                base;
		base = errors;
		for (int n = 0; n < FLOW_RUNS; n++) begin
			pc = {27'(rand_bits(27)), 5'd0};
			line = random_line();
			for (int k = 0; k < `GROUP_SLOTS; k++)
				line[k*`INSN_BITS +: `INSN_BITS] = random_insn();
			apply_group(pc, line, 1'b0, 2'b00, 3'd0, 1'b0, 1'b0, '0);
			expected_flow(pc, line, bsr, call, ret, tgt, rpc);
			check_flag("do_bsr_o", do_bsr_o, bsr);
			check_flag("do_call_o", do_call_o, call);
			check_flag("do_ret_o", do_ret_o, ret);
			check_pc("bsr_tgt_o", bsr_tgt_o, tgt);
			check_pc("ret_pc_o", ret_pc_o, rpc);
		end
		report_test("flow", base);
	endtask

	initial begin
		lfsr = 32'h6ea6;
		checks = 0;
		errors = 0;
		rst_i = 1'b1;
		en_i = 1'b0;
		advance_i = 1'b0;
		pc_i = '0;
		line_i = '0;
		nmi_i = 1'b0;
		irq_i = 1'b0;
		irq_level_i = 3'd0;
		stomp_i = 1'b0;
		branchmiss_i = 1'b0;
		misspc_i = '0;
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;
		test_reset();
		test_alignment();
		test_redundant();
		test_interrupt();
		test_branch_miss();
		test_flow();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
